//--- design/ejtagPkg.sv
package ejtagPkg;

  //////////////////// register map
  localparam logic [3:0] IBS_CHAN = 4'hF;   // upper nibble of the status word address.
  localparam logic [1:0] OFS_IBS  = 2'd0;
  localparam logic [1:0] OFS_ADDR = 2'd0;
  localparam logic [1:0] OFS_CTRL = 2'd1;
  localparam logic [1:0] OFS_MASK = 2'd2;

  localparam int CTRL_BREAK_BIT = 0;
  localparam int CTRL_TRACE_BIT = 2;
  localparam int IBS_NUM_LSB    = 24;       // channel count field in IBS.
  localparam int HIT_W          = 15;

  typedef struct packed {
    logic [5:0]  addr;                      // word address, byte bits 7:2.
    logic        write;
    logic [31:0] wdata;
  } regReqT;

  typedef struct packed {
    logic [31:0] rdata;
  } regRspT;

  typedef enum logic [2:0] {SEL_NONE, SEL_IBS, SEL_ADDR, SEL_CTRL, SEL_MASK} regSelT;

  typedef struct packed {
    logic        strobe;
    logic        write;
    regSelT      sel;
    logic [3:0]  chan;
    logic [31:0] data;
  } regAccessT;

  typedef struct packed {
    logic [31:0] pc;
    logic [7:0]  tag;
  } fetchT;

  typedef struct packed {
    logic [31:0]      pc;
    logic [7:0]       tag;
    logic [HIT_W-1:0] hit;                  // per-channel break hits.
    logic             breakHit;
    logic             traceHit;
  } ibrkResultT;

endpackage

//--- design/skidStage.sv
`timescale 1ns/1ns

module skidStage #(
  parameter type payloadT = logic
) (
  input  logic    CORE_CLOCK,
  input  logic    rstN,
  input  payloadT inData,
  input  logic    inValid,
  output logic    inReady,
  output payloadT outData,
  output logic    outValid,
  input  logic    outReady
);

  logic loadEn;

  // empty, or the held entry leaves this cycle.
  assign inReady = !outValid || outReady;
  assign loadEn  = inValid && inReady;

  always_ff @(posedge CORE_CLOCK or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  // payload register.
  always_ff @(posedge CORE_CLOCK) begin
    if (loadEn) begin
      outData <= inData;
    end
  end

  //////////////////// checks
  // a stalled output holds its entry and its data.
  holdStable: assert property (
    @(posedge CORE_CLOCK) disable iff (!rstN)
    outValid && !outReady |=> outValid && $stable(outData)
  );

endmodule

//--- design/ibrkMatch.sv
`timescale 1ns/1ns

module ibrkMatch import ejtagPkg::*; #(
  parameter int numIbrk = 4
) (
  input  logic        CORE_CLOCK,
  input  logic        rstN,
  input  fetchT       fetch,
  input  logic        fetchValid,
  output logic        fetchReady,
  output ibrkResultT  result,
  output logic        resultValid,
  input  logic        resultReady,
  input  regAccessT   access,
  output logic [31:0] rdata,
  input  logic        debugMode
);

  logic [31:1] addrReg [numIbrk];
  logic [31:1] maskReg [numIbrk];            // set bit means don't compare.
  logic [1:0]  ctrlReg [numIbrk];            // [0] break enable, [1] trace enable.
  logic [numIbrk-1:0] ibsStatus;

  logic [numIbrk-1:0] rawHit;
  logic [numIbrk-1:0] breakVec;
  logic [numIbrk-1:0] traceVec;
  logic [31:0]        ibsWord;
  logic               regWrite;
  logic               fetchTaken;

  //////////////////// compare
  always_comb begin
    for (int i = 0; i < numIbrk; i++) begin
      rawHit[i]   = &((fetch.pc[31:1] ~^ addrReg[i]) | maskReg[i]);
      breakVec[i] = rawHit[i] & ctrlReg[i][0] & ~debugMode;
      traceVec[i] = rawHit[i] & ctrlReg[i][1] & ~debugMode;
    end
  end

  always_comb begin
    result                  = '0;
    result.pc               = fetch.pc;
    result.tag              = fetch.tag;
    result.hit[numIbrk-1:0] = breakVec;
    result.breakHit         = |breakVec;
    result.traceHit         = |traceVec;
  end

  assign resultValid = fetchValid;
  assign fetchReady  = resultReady;           // no storage here, the result stage decides.
  assign fetchTaken  = fetchValid & resultReady;

  //////////////////// registers
  assign regWrite = access.strobe & access.write;

  always_ff @(posedge CORE_CLOCK or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numIbrk; i++) begin
        addrReg[i] <= '0;
        maskReg[i] <= '0;
        ctrlReg[i] <= '0;
      end
    end else if (regWrite) begin
      for (int i = 0; i < numIbrk; i++) begin
        if (access.chan == 4'(i)) begin
          case (access.sel)
            SEL_ADDR: addrReg[i] <= access.data[31:1];
            SEL_CTRL: ctrlReg[i] <= {access.data[CTRL_TRACE_BIT],
                                     access.data[CTRL_BREAK_BIT]};
            SEL_MASK: maskReg[i] <= access.data[31:1];
            default:  ;
          endcase
        end
      end
    end
  end

  // sticky break status; a debugger write takes priority over new hits.
  always_ff @(posedge CORE_CLOCK or negedge rstN) begin
    if (!rstN) begin
      ibsStatus <= '0;
    end else if (regWrite && access.sel == SEL_IBS) begin
      ibsStatus <= access.data[numIbrk-1:0];
    end else if (fetchTaken) begin
      ibsStatus <= ibsStatus | breakVec;
    end
  end

  //////////////////// read data
  always_comb begin
    ibsWord                       = '0;
    ibsWord[IBS_NUM_LSB +: 4]     = 4'(numIbrk);
    ibsWord[numIbrk-1:0]          = ibsStatus;
  end

  always_comb begin
    rdata = '0;
    if (access.sel == SEL_IBS) begin
      rdata = ibsWord;
    end
    for (int i = 0; i < numIbrk; i++) begin
      if (access.chan == 4'(i)) begin
        case (access.sel)
          SEL_ADDR: rdata = {addrReg[i], 1'b0};
          SEL_CTRL: begin
            rdata[CTRL_BREAK_BIT] = ctrlReg[i][0];
            rdata[CTRL_TRACE_BIT] = ctrlReg[i][1];
          end
          SEL_MASK: rdata = {maskReg[i], 1'b0};
          default:  ;
        endcase
      end
    end
  end

  //////////////////// checks
  // the bus decoder must filter out absent channels.
  chanInRange: assert property (
    @(posedge CORE_CLOCK) disable iff (!rstN)
    access.strobe && (access.sel inside {SEL_ADDR, SEL_CTRL, SEL_MASK})
      |-> access.chan < 4'(numIbrk)
  );

endmodule

//--- design/dbgRegBus.sv
`timescale 1ns/1ns

module dbgRegBus import ejtagPkg::*; #(
  parameter int numIbrk = 4
) (
  input  logic        CORE_CLOCK,
  input  logic        rstN,
  input  regReqT      req,
  input  logic        reqValid,
  output logic        reqReady,
  output regRspT      rsp,
  output logic        rspValid,
  input  logic        rspReady,
  output regAccessT   access,
  input  logic [31:0] rdata
);

  logic [3:0] reqChan;
  logic [1:0] reqOfs;
  regSelT     reqSel;
  logic       accept;

  assign reqChan = req.addr[5:2];
  assign reqOfs  = req.addr[1:0];

  //////////////////// decode
  always_comb begin
    reqSel = SEL_NONE;
    if (reqChan == IBS_CHAN) begin
      if (reqOfs == OFS_IBS) reqSel = SEL_IBS;
    end else if (reqChan < 4'(numIbrk)) begin
      case (reqOfs)
        OFS_ADDR: reqSel = SEL_ADDR;
        OFS_CTRL: reqSel = SEL_CTRL;
        OFS_MASK: reqSel = SEL_MASK;
        default:  reqSel = SEL_NONE;            // offset 3 is unused.
      endcase
    end
  end

  // one request in flight; take a new one as the old response leaves.
  assign reqReady = !rspValid || rspReady;
  assign accept   = reqValid && reqReady;

  assign access.strobe = accept;
  assign access.write  = req.write;
  assign access.sel    = reqSel;
  assign access.chan   = reqChan;
  assign access.data   = req.wdata;

  //////////////////// response
  always_ff @(posedge CORE_CLOCK or negedge rstN) begin
    if (!rstN) begin
      rspValid <= 1'b0;
    end else if (reqReady) begin
      rspValid <= reqValid;
    end
  end

  // sampled before the write of the same access lands.
  always_ff @(posedge CORE_CLOCK) begin
    if (accept) begin
      rsp.rdata <= rdata;
    end
  end

  //////////////////// checks
  rspHeld: assert property (
    @(posedge CORE_CLOCK) disable iff (!rstN)
    rspValid && !rspReady |=> rspValid && $stable(rsp)
  );

endmodule

//--- design/ejtagDebugTop.sv
`timescale 1ns/1ns

module ejtagDebugTop import ejtagPkg::*; #(
  parameter int numIbrk = 4
) (
  input  logic       CORE_CLOCK,
  input  logic       rstN,
  input  fetchT      fetchIn,
  input  logic       fetchValid,
  output logic       fetchReady,
  output ibrkResultT result,
  output logic       resultValid,
  input  logic       resultReady,
  input  regReqT     regReq,
  input  logic       regReqValid,
  output logic       regReqReady,
  output regRspT     regRsp,
  output logic       regRspValid,
  input  logic       regRspReady,
  input  logic       debugMode
);

  fetchT       fetchQ;
  logic        fetchQValid;
  logic        fetchQReady;
  ibrkResultT  matchResult;
  logic        matchValid;
  logic        matchReady;
  regAccessT   access;
  logic [31:0] rdata;

  skidStage #(.payloadT(fetchT)) i_fetchStage (
    .CORE_CLOCK, .rstN,
    .inData(fetchIn),  .inValid(fetchValid),  .inReady(fetchReady),
    .outData(fetchQ),  .outValid(fetchQValid), .outReady(fetchQReady)
  );

  ibrkMatch #(.numIbrk(numIbrk)) i_ibrkMatch (
    .CORE_CLOCK, .rstN,
    .fetch(fetchQ),        .fetchValid(fetchQValid), .fetchReady(fetchQReady),
    .result(matchResult),  .resultValid(matchValid), .resultReady(matchReady),
    .access, .rdata, .debugMode
  );

  skidStage #(.payloadT(ibrkResultT)) i_resultStage (
    .CORE_CLOCK, .rstN,
    .inData(matchResult), .inValid(matchValid),  .inReady(matchReady),
    .outData(result),     .outValid(resultValid), .outReady(resultReady)
  );

  dbgRegBus #(.numIbrk(numIbrk)) i_dbgRegBus (
    .CORE_CLOCK, .rstN,
    .req(regReq), .reqValid(regReqValid), .reqReady(regReqReady),
    .rsp(regRsp), .rspValid(regRspValid), .rspReady(regRspReady),
    .access, .rdata
  );

endmodule

//--- tests/tbRefModel.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// mirror of the debug registers, updated on every bus write.
logic [31:0]        modelAddr [numIbrk];
logic [31:0]        modelMask [numIbrk];
logic [31:0]        modelCtrl [numIbrk];
logic [numIbrk-1:0] modelIbs;
logic               modelDebug;

function automatic void modelReset();
  for (int ch = 0; ch < numIbrk; ch++) begin
    modelAddr[ch] = '0;
    modelMask[ch] = '0;
    modelCtrl[ch] = '0;
  end
  modelIbs   = '0;
  modelDebug = 1'b0;
endfunction

// true for the status word and the three words of each present channel.
function automatic logic isMapped(input logic [5:0] addr);
  if (addr[5:2] == 4'hF) begin
    return addr[1:0] == 2'd0;
  end
  return (int'(addr[5:2]) < numIbrk) && (addr[1:0] != 2'd3);
endfunction

function automatic void modelWrite(input logic [5:0] addr, input logic [31:0] data);
  int idx;
  idx = int'(addr[5:2]);
  if (!isMapped(addr)) begin
    return;
  end
  if (addr[5:2] == 4'hF) begin
    modelIbs = data[numIbrk-1:0];         // a write replaces the sticky bits.
  end else begin
    case (addr[1:0])
      2'd0:    modelAddr[idx] = data & 32'hFFFF_FFFE;
      2'd1:    modelCtrl[idx] = data & 32'h0000_0005;
      default: modelMask[idx] = data & 32'hFFFF_FFFE;
    endcase
  end
endfunction

function automatic logic [31:0] expectedRead(input logic [5:0] addr);
  int          idx;
  logic [31:0] value;
  idx   = int'(addr[5:2]);
  value = '0;
  if (!isMapped(addr)) begin
    return value;
  end
  if (addr[5:2] == 4'hF) begin
    value[27:24]        = 4'(numIbrk);
    value[numIbrk-1:0]  = modelIbs;
  end else begin
    case (addr[1:0])
      2'd0:    value = modelAddr[idx];
      2'd1:    value = modelCtrl[idx];
      default: value = modelMask[idx];
    endcase
  end
  return value;
endfunction

function automatic ibrkResultT expectedResult(input logic [31:0] pc, input logic [7:0] tag);
  ibrkResultT  res;
  logic [31:0] diff;
  res     = '0;
  res.pc  = pc;
  res.tag = tag;
  for (int ch = 0; ch < numIbrk; ch++) begin
    diff = (pc ^ modelAddr[ch]) & ~modelMask[ch] & 32'hFFFF_FFFE;   // pc bit 0 ignored.
    if (diff == '0 && !modelDebug) begin
      if (modelCtrl[ch][0]) begin
        res.hit[ch]  = 1'b1;
        res.breakHit = 1'b1;
      end
      if (modelCtrl[ch][2]) begin
        res.traceHit = 1'b1;
      end
    end
  end
  return res;
endfunction

`endif

//--- tests/tbEjtagDebug.sv
`timescale 1ns/1ns

module tbEjtagDebug import ejtagPkg::*; ();

  localparam int numIbrk        = 4;
  localparam int numRandom      = 300;
  localparam int numFetches     = numIbrk * 33 + numRandom + 6;
  localparam int numAccesses    = 2 * 64 + (63 - 3 * numIbrk) + numIbrk * 9 + 8;
  localparam int watchdogCycles = (numFetches + numAccesses) * 20;
  localparam logic [5:0] ibsAddr = {IBS_CHAN, OFS_IBS};

  // channel setup for the matching tests.
  localparam logic [31:0] cfgAddr [4] = '{32'h0000_1000, 32'h0000_2000,
                                          32'h8000_0040, 32'h1234_5678};
  localparam logic [31:0] cfgMask [4] = '{32'h0, 32'h0000_00FE, 32'h0, 32'hFFFF_0000};
  localparam logic [31:0] cfgCtrl [4] = '{32'h1, 32'h4, 32'h5, 32'h1};

  logic       CORE_CLOCK;
  logic       rstN;
  fetchT      fetchIn;
  logic       fetchValid;
  logic       fetchReady;
  ibrkResultT result;
  logic       resultValid;
  logic       resultReady;
  regReqT     regReq;
  logic       regReqValid;
  logic       regReqReady;
  regRspT     regRsp;
  logic       regRspValid;
  logic       regRspReady;
  logic       debugMode;

  logic       randomReady;
  logic [7:0] tagCount;
  ibrkResultT expQ [$];                     // expected results in fetch order.

  `include "tbRefModel.svh"

  ejtagDebugTop #(.numIbrk(numIbrk)) i_dut (
    .CORE_CLOCK, .rstN,
    .fetchIn, .fetchValid, .fetchReady,
    .result, .resultValid, .resultReady,
    .regReq, .regReqValid, .regReqReady,
    .regRsp, .regRspValid, .regRspReady,
    .debugMode
  );

  initial begin
    CORE_CLOCK = 1'b0;
    forever #50 CORE_CLOCK = ~CORE_CLOCK;
  end

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  //////////////////// bus and fetch drivers
  task automatic busAccess(input logic [5:0] addr, input logic write,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    regReq.addr  = addr;
    regReq.write = write;
    regReq.wdata = wdata;
    regReqValid  = 1'b1;
    @(negedge CORE_CLOCK);
    while (!regReqReady) @(negedge CORE_CLOCK);
    @(posedge CORE_CLOCK);
    #10;
    regReqValid = 1'b0;
    @(negedge CORE_CLOCK);
    while (!regRspValid) @(negedge CORE_CLOCK);
    rdata = regRsp.rdata;                   // taken at the next edge since ready is held high.
    @(posedge CORE_CLOCK);
    #10;
  endtask

  task automatic writeReg(input logic [5:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    busAccess(addr, 1'b1, data, unused);
    modelWrite(addr, data);
  endtask

  task automatic checkRead(input logic [5:0] addr);
    logic [31:0] got;
    logic [31:0] exp;
    exp = expectedRead(addr);
    busAccess(addr, 1'b0, 32'h0, got);
    assert (got === exp) else stopOnError($sformatf(
      "FAILED at %0t: read of word address %02h returned %08h, expected %08h",
      $time, addr, got, exp));
  endtask

  task automatic sendFetch(input logic [31:0] pc);
    ibrkResultT exp;
    exp = expectedResult(pc, tagCount);
    expQ.push_back(exp);
    if (exp.breakHit) begin
      modelIbs = modelIbs | exp.hit[numIbrk-1:0];
    end
    fetchIn.pc  = pc;
    fetchIn.tag = tagCount;
    fetchValid  = 1'b1;
    @(negedge CORE_CLOCK);
    while (!fetchReady) @(negedge CORE_CLOCK);
    @(posedge CORE_CLOCK);
    #10;
    fetchValid = 1'b0;
    tagCount++;
  endtask

  task automatic drainResults();
    while (expQ.size() != 0) begin
      @(posedge CORE_CLOCK);
      #10;
    end
  endtask

  task automatic setDebug(input logic value);
    debugMode  = value;
    modelDebug = value;
  endtask

  //////////////////// sink and checker
  initial begin : readyDriver
    forever begin
      @(posedge CORE_CLOCK);
      #10;
      resultReady = randomReady ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  // a result seen valid and ready mid-cycle transfers at the next edge.
  initial begin : compareResults
    ibrkResultT expected;
    forever begin
      @(negedge CORE_CLOCK);
      if (rstN && resultValid && resultReady) begin
        assert (expQ.size() != 0) else stopOnError("a result arrived with no fetch outstanding");
        expected = expQ.pop_front();
        assert (result === expected) else stopOnError($sformatf(
          {"FAILED at %0t: result pc %08h tag %02h hit %04h brk %0b trc %0b,",
           " expected pc %08h tag %02h hit %04h brk %0b trc %0b"},
          $time, result.pc, result.tag, result.hit, result.breakHit, result.traceHit,
          expected.pc, expected.tag, expected.hit, expected.breakHit, expected.traceHit));
      end
    end
  end

  initial begin : watchdog
    repeat (watchdogCycles) @(posedge CORE_CLOCK);
    stopOnError("timeout, the test did not finish within the expected number of cycles");
  end

  //////////////////// test sequence
  initial begin : mainSequence
    logic [31:0] pc;
    void'($urandom(32'h1bc09c80));
    rstN        = 1'b0;
    fetchIn     = '0;
    fetchValid  = 1'b0;
    resultReady = 1'b1;
    regReq      = '0;
    regReqValid = 1'b0;
    regRspReady = 1'b1;
    debugMode   = 1'b0;
    randomReady = 1'b0;
    tagCount    = '0;
    modelReset();
    repeat (2) @(posedge CORE_CLOCK);
    #10;
    rstN = 1'b1;

    // reset values.
    @(negedge CORE_CLOCK);
    assert (!resultValid && !regRspValid) else stopOnError("valid outputs are high after reset");
    @(posedge CORE_CLOCK);
    #10;
    for (int a = 0; a < 64; a++) checkRead(6'(a));

    // readback of every channel and writes to unmapped words.
    for (int ch = 0; ch < numIbrk; ch++) begin
      writeReg({4'(ch), OFS_ADDR}, $urandom);
      writeReg({4'(ch), OFS_CTRL}, $urandom);
      writeReg({4'(ch), OFS_MASK}, $urandom);
      checkRead({4'(ch), OFS_ADDR});
      checkRead({4'(ch), OFS_CTRL});
      checkRead({4'(ch), OFS_MASK});
    end
    for (int a = 0; a < 64; a++) begin
      if (!isMapped(6'(a))) writeReg(6'(a), 32'hFFFF_FFFF);
    end
    for (int a = 0; a < 64; a++) checkRead(6'(a));

    // exact matches, pc bit 0 and single-bit near misses.
    for (int ch = 0; ch < numIbrk; ch++) begin
      writeReg({4'(ch), OFS_ADDR}, cfgAddr[ch]);
      writeReg({4'(ch), OFS_MASK}, cfgMask[ch]);
      writeReg({4'(ch), OFS_CTRL}, cfgCtrl[ch]);
    end
    randomReady = 1'b1;
    for (int ch = 0; ch < numIbrk; ch++) begin
      sendFetch(cfgAddr[ch]);
      sendFetch(cfgAddr[ch] | 32'h1);
      for (int b = 1; b < 32; b++) sendFetch(cfgAddr[ch] ^ (32'h1 << b));
    end
    repeat (numRandom) begin
      pc = $urandom;
      if ($urandom_range(0, 1) == 1) begin
        pc = {cfgAddr[$urandom_range(0, numIbrk - 1)][31:8], pc[7:0]};   // near a channel.
      end
      sendFetch(pc);
    end
    drainResults();
    checkRead(ibsAddr);

    // a status write replaces the bits and hits stay sticky.
    writeReg(ibsAddr, 32'h0000_000A);
    checkRead(ibsAddr);
    sendFetch(cfgAddr[0]);
    drainResults();
    checkRead(ibsAddr);
    writeReg(ibsAddr, 32'h0);
    checkRead(ibsAddr);

    // no hits in debug mode.
    setDebug(1'b1);
    for (int ch = 0; ch < numIbrk; ch++) sendFetch(cfgAddr[ch]);
    drainResults();
    checkRead(ibsAddr);
    setDebug(1'b0);
    sendFetch(cfgAddr[2]);
    drainResults();
    checkRead(ibsAddr);

    repeat (5) @(posedge CORE_CLOCK);       // any extra result would show up here.

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+tests
design/ejtagPkg.sv
design/skidStage.sv
design/ibrkMatch.sv
design/dbgRegBus.sv
design/ejtagDebugTop.sv
tests/tbEjtagDebug.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1

logFile=sim.log
rm -rf obj_dir "$logFile"

if ! verilator --binary --timing --assert -Wno-fatal --top-module tbEjtagDebug \
    -Mdir obj_dir -f filelist.f; then
  echo "build failed"
  exit 1
fi

./obj_dir/VtbEjtagDebug > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Done: errors found" "$logFile"; then
  echo "simulation failed"
  exit 1
fi
if [ "$simStatus" -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi
echo "simulation passed"
exit 0
